/* files.f */
+incdir+include
source/exu_pkg.sv
source/exu_alu.sv
source/exu_regfile.sv
source/exu_rpt_counter.sv
source/exu_ctrl.sv
source/exu_top.sv
testbench/exu_checker.sv
testbench/exu_tb.sv

/* include/exu_consts.svh */
/* sizes and encodings for the execution unit
   op codes above ALU_BS1F are not decoded and behave as a move */
`ifndef EXU_CONSTS_SVH
`define EXU_CONSTS_SVH

// datapath
`define EXU_DATA_W 32       // register and ALU width
`define EXU_NREG   8        // register count, 3 address bits
`define EXU_RPT_W  4        // repeat field, 1 to 16 runs

// ALU operation select
`define ALU_MOVE 4'd0       // op2 straight through
`define ALU_ADD  4'd1
`define ALU_SUB  4'd2       // op0 - op2, carry is borrow
`define ALU_AND  4'd3
`define ALU_OR   4'd4
`define ALU_XOR  4'd5
`define ALU_CPL  4'd6       // ~op0, op2 unused
`define ALU_BS1F 4'd7       // lowest set bit of op0[15:0]

// operand width
`define W_BYTE 2'd0
`define W_WORD 2'd1
`define W_LONG 2'd2         // code 3 also runs as long

// instruction form bit
// set selects the immediate view of the instruction word
`define EXU_FORM_IMM 1'b1

`endif

/* run_sim.sh */
#!/bin/sh
# build the execution unit testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f files.f --top-module exu_tb -Mdir obj_dir \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vexu_tb +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -qx "PASS: all tests" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* source/exu_alu.sv */
/* registered ALU, dout and flags change one cycle after alu_en
   operands are masked to w before add and sub so the carry comes out of that width
   width code 3 runs as long */
`timescale 1ns/1ns
`include "exu_consts.svh"

module exu_alu import exu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   alu_en,
    input  logic [OP_W-1:0]        sel,     // operation
    input  logic [1:0]             w,       // byte, word or long
    input  logic                   opmux,   // op2 from imm
    input  logic                   fb_sel,  // op0 from own dout
    input  logic [`EXU_DATA_W-1:0] op0,
    input  logic [`EXU_DATA_W-1:0] op1,
    input  logic [`EXU_DATA_W-1:0] imm,
    output logic [`EXU_DATA_W-1:0] dout,
    output flags_t                 flags
);

    logic [`EXU_DATA_W-1:0] a;       // op0 after the feedback mux
    logic [`EXU_DATA_W-1:0] op2;
    logic [`EXU_DATA_W-1:0] mask;
    logic [`EXU_DATA_W-1:0] a_m;
    logic [`EXU_DATA_W-1:0] b_m;
    logic [`EXU_DATA_W:0]   sum;     // one extra bit for long carry
    logic [`EXU_DATA_W:0]   diff;
    logic [`EXU_DATA_W-1:0] raw;     // before width masking
    logic [`EXU_DATA_W-1:0] res;
    logic [3:0]             bs1f_idx;
    logic                   cy;

    // bit just above the selected width
    function automatic logic width_bit(input logic [`EXU_DATA_W:0] v, input logic [1:0] wc);
        case (wc)
            `W_BYTE: return v[8];
            `W_WORD: return v[16];
            default: return v[`EXU_DATA_W];
        endcase
    endfunction

    assign a   = fb_sel ? dout : op0;   // repeat chain
    assign op2 = opmux ? imm : op1;

    always_comb begin
        case (w)
            `W_BYTE: mask = 32'h0000_00ff;
            `W_WORD: mask = 32'h0000_ffff;
            `W_LONG: mask = 32'hffff_ffff;
            default: mask = 32'hffff_ffff;
        endcase
    end

    assign a_m  = a & mask;
    assign b_m  = op2 & mask;
    assign sum  = {1'b0, a_m} + {1'b0, b_m};
    assign diff = {1'b0, a_m} - {1'b0, b_m};  // wraps to all ones on borrow

    // priority search, lowest set bit wins
    always_comb begin
        bs1f_idx = '0;
        for (int i = 15; i >= 0; i--) begin
            if (a[i]) bs1f_idx = 4'(i);
        end
    end

    always_comb begin
        cy = 1'b0;                      // cleared unless add or sub
        case (sel)
            `ALU_MOVE: raw = op2;
            `ALU_ADD: begin
                raw = sum[`EXU_DATA_W-1:0];
                cy  = width_bit(sum, w);
            end
            `ALU_SUB: begin
                raw = diff[`EXU_DATA_W-1:0];
                cy  = width_bit(diff, w);
            end
            `ALU_AND:  raw = a & op2;
            `ALU_OR:   raw = a | op2;
            `ALU_XOR:  raw = a ^ op2;
            `ALU_CPL:  raw = ~a;
            `ALU_BS1F: raw = {28'd0, bs1f_idx};  // 0 also when nothing set
            default:   raw = op2;
        endcase
    end

    assign res = raw & mask;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dout  <= '0;
            flags <= '0;
        end else if (alu_en) begin
            dout        <= res;
            flags.carry <= cy;
            flags.zero  <= (res == '0);
        end
    end

endmodule

/* source/exu_ctrl.sv */
/* sequences IDLE, READ, EXEC and WRITE for one instruction
   start is taken only in IDLE, done is high exactly rpt+3 cycles after it
   immediate form always runs once */
`timescale 1ns/1ns
`include "exu_consts.svh"

module exu_ctrl import exu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  instr_u                 instr,
    output logic                   busy,
    output logic                   done,
    output logic [REG_AW-1:0]      ra,
    output logic [REG_AW-1:0]      rb,
    output logic                   alu_en,
    output logic [OP_W-1:0]        sel,
    output logic [1:0]             w,
    output logic                   opmux,
    output logic                   fb_sel,
    output logic [`EXU_DATA_W-1:0] imm,
    output logic                   rpt_load,
    output logic [`EXU_RPT_W-1:0]  rpt_value,
    output logic                   rpt_step,
    input  logic                   last,
    input  logic [`EXU_DATA_W-1:0] alu_dout,
    output reg_wr_t                wb
);

    typedef enum logic [1:0] {IDLE, READ, EXEC, WRITE} state_t;

    state_t            state;
    state_t            state_nx;
    instr_u            ir;       // latched on an accepted start
    logic              is_imm;
    logic              chain;    // past the first EXEC cycle
    logic [REG_AW-1:0] dst;

    always_ff @(posedge clk) begin
        if (!rst_n) state <= IDLE;
        else        state <= state_nx;
    end

    always_comb begin
        state_nx = state;
        case (state)
            IDLE:  if (start) state_nx = READ;   // ignored otherwise
            READ:  state_nx = EXEC;
            EXEC:  if (last) state_nx = WRITE;
            WRITE: state_nx = IDLE;
            default: state_nx = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) ir <= instr;
    end

    // first EXEC cycle reads the register, later ones the ALU's own result
    always_ff @(posedge clk) begin
        if (!rst_n) chain <= 1'b0;
        else        chain <= (state == EXEC);
    end

    // decode, op and w sit at the same place in both views
    assign is_imm = (ir.rf.form == `EXU_FORM_IMM);
    assign dst    = ir.rf.dst;                    // same bits in the imf view
    assign sel    = ir.rf.op;
    assign w      = ir.rf.w;
    assign ra     = dst;                          // op0 is the old dst
    assign rb     = ir.rf.src;                    // unused in imm form
    assign opmux  = is_imm;
    assign imm    = {{(`EXU_DATA_W-IMM_W){1'b0}}, ir.imf.imm};
    assign rpt_value = is_imm ? '0 : ir.rf.rpt;

    assign busy     = (state != IDLE);
    assign done     = (state == WRITE);
    assign alu_en   = (state == EXEC);
    assign fb_sel   = (state == EXEC) && chain;
    assign rpt_load = (state == READ);
    assign rpt_step = (state == EXEC);            // counter holds at zero

    assign wb.en   = (state == WRITE);
    assign wb.addr = dst;
    assign wb.data = alu_dout;

endmodule

/* source/exu_pkg.sv */
/* shared types for the execution unit
   both instruction views keep op, form, w and dst at the same bit positions */
`include "exu_consts.svh"

package exu_pkg;

    localparam int OP_W   = 4;                    // ALU op code bits
    localparam int REG_AW = $clog2(`EXU_NREG);    // register address bits
    localparam int IMM_W  = 16;                   // immediate field, zero extended

    // padding so both views fill one word
    localparam int RF_PAD  = `EXU_DATA_W - OP_W - 1 - 2 - 2 * REG_AW - `EXU_RPT_W;
    localparam int IMF_PAD = `EXU_DATA_W - OP_W - 1 - 2 - REG_AW - IMM_W;

    // register form, src register as op2, repeat count
    typedef struct packed {
        logic [OP_W-1:0]       op;
        logic                  form;   // clear here
        logic [1:0]            w;
        logic [REG_AW-1:0]     dst;
        logic [REG_AW-1:0]     src;
        logic [`EXU_RPT_W-1:0] rpt;    // runs = rpt+1
        logic [RF_PAD-1:0]     rsvd;
    } reg_form_t;

    // immediate form, always a single run
    typedef struct packed {
        logic [OP_W-1:0]   op;
        logic              form;       // set here
        logic [1:0]        w;
        logic [REG_AW-1:0] dst;
        logic [IMM_W-1:0]  imm;
        logic [IMF_PAD-1:0] rsvd;
    } imm_form_t;

    // one instruction word, form bit picks the view
    typedef union packed {
        reg_form_t rf;
        imm_form_t imf;
    } instr_u;

    typedef struct packed {
        logic carry;                   // carry or borrow out of the width
        logic zero;                    // masked result is zero
    } flags_t;

    // single register file write
    typedef struct packed {
        logic                   en;
        logic [REG_AW-1:0]      addr;
        logic [`EXU_DATA_W-1:0] data;
    } reg_wr_t;

endpackage

/* source/exu_regfile.sv */
/* eight registers, cleared by reset, asynchronous reads
   write-back has priority, a colliding ld write is dropped */
`timescale 1ns/1ns
`include "exu_consts.svh"

module exu_regfile import exu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [REG_AW-1:0]      ra,      // op0 address
    input  logic [REG_AW-1:0]      rb,      // op1 address
    output logic [`EXU_DATA_W-1:0] rd_a,
    output logic [`EXU_DATA_W-1:0] rd_b,
    input  reg_wr_t                wb,      // from the controller
    input  reg_wr_t                ld       // external preload
);

    logic [`EXU_DATA_W-1:0] regs [`EXU_NREG];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `EXU_NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en) begin
            regs[wb.addr] <= wb.data;  // result write-back
        end else if (ld.en) begin
            regs[ld.addr] <= ld.data;  // loader only when wb idle
        end
    end

    // combinational read ports
    // a write shows up on the read side the next cycle
    assign rd_a = regs[ra];
    assign rd_b = regs[rb];

endmodule

/* source/exu_rpt_counter.sv */
/* repeat counter, loaded with rpt and stepped down once per run
   last is high whenever the count is zero, also before any load */
`timescale 1ns/1ns
`include "exu_consts.svh"

module exu_rpt_counter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  rpt_load,   // takes rpt_value
    input  logic [`EXU_RPT_W-1:0] rpt_value,
    input  logic                  rpt_step,   // one run done
    output logic                  last        // final run this cycle
);

    logic [`EXU_RPT_W-1:0] cnt;    // runs still to go after this one

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (rpt_load) begin
            cnt <= rpt_value;
        end else if (rpt_step && cnt != '0) begin
            cnt <= cnt - 1'b1;     // holds at zero
        end
    end

    assign last = (cnt == '0);

endmodule

/* source/exu_top.sv */
/* execution unit top, registers preloaded through ld
   result and flags are the ALU's registered outputs */
`timescale 1ns/1ns
`include "exu_consts.svh"

module exu_top import exu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,    // strobe, ignored while busy
    input  instr_u                 instr,
    input  reg_wr_t                ld,
    output logic                   busy,
    output logic                   done,     // one-cycle pulse
    output logic [`EXU_DATA_W-1:0] result,
    output flags_t                 flags
);

    logic [REG_AW-1:0]      ra;
    logic [REG_AW-1:0]      rb;
    logic [`EXU_DATA_W-1:0] rd_a;
    logic [`EXU_DATA_W-1:0] rd_b;
    logic                   alu_en;
    logic [OP_W-1:0]        sel;
    logic [1:0]             w;
    logic                   opmux;
    logic                   fb_sel;
    logic [`EXU_DATA_W-1:0] imm;
    logic                   rpt_load;
    logic [`EXU_RPT_W-1:0]  rpt_value;
    logic                   rpt_step;
    logic                   last;
    reg_wr_t                wb;

    exu_ctrl ctrl_inst (
        .clk, .rst_n, .start, .instr, .busy, .done,
        .ra, .rb, .alu_en, .sel, .w, .opmux, .fb_sel, .imm,
        .rpt_load, .rpt_value, .rpt_step, .last,
        .alu_dout (result),
        .wb
    );

    exu_rpt_counter rpt_inst (
        .clk, .rst_n, .rpt_load, .rpt_value, .rpt_step, .last
    );

    exu_alu alu_inst (
        .clk, .rst_n, .alu_en, .sel, .w, .opmux, .fb_sel,
        .op0  (rd_a),
        .op1  (rd_b),
        .imm,
        .dout (result),
        .flags
    );

    exu_regfile regfile_inst (
        .clk, .rst_n, .ra, .rb, .rd_a, .rd_b, .wb, .ld
    );

endmodule

/* testbench/exu_checker.sv */
/* timing checks on done, busy and the zero flag, bound into exu_top
   all checks except the reset one are gated by rst_n */
`timescale 1ns/1ns
`include "exu_consts.svh"

module exu_checker import exu_pkg::*; (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   busy,
    input logic                   done,
    input logic [`EXU_DATA_W-1:0] result,
    input flags_t                 flags
);

    int unsigned fails = 0;    // failed checks so far

    // outputs cleared one edge after a reset cycle
    reset_clear: assert property (@(posedge clk) !rst_n |=> (!busy && !done && result == '0))
        else begin $error("busy, done or result not cleared by reset"); fails++; end

    // done is a single cycle strobe
    done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin $error("done held high for more than one cycle"); fails++; end

    busy_at_done: assert property (@(posedge clk) disable iff (!rst_n) done |-> busy)
        else begin $error("done pulsed while busy was low"); fails++; end

    // back to IDLE right after WRITE
    busy_falls: assert property (@(posedge clk) disable iff (!rst_n) done |=> !busy)
        else begin $error("busy still high in the cycle after done"); fails++; end

    // result and flags hold after WRITE, zero has to agree
    zero_flag: assert property (@(posedge clk) disable iff (!rst_n)
                                done |=> (flags.zero == (result == '0)))
        else begin $error("zero flag disagrees with result after done"); fails++; end

endmodule

bind exu_top exu_checker exu_checker_inst (
    .clk, .rst_n, .busy, .done, .result, .flags
);

/* testbench/exu_tb.sv */
/* self-checking testbench for exu_top, expects exu_checker bound in
   registers are preloaded through ld, results come from a separate ALU model */
`timescale 1ns/1ns
`include "exu_consts.svh"

module exu_tb import exu_pkg::*; ();

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   start;
    instr_u                 instr;
    reg_wr_t                ld;
    logic                   busy;
    logic                   done;
    logic [`EXU_DATA_W-1:0] result;
    flags_t                 flags;

    logic [31:0] lfsr = 32'h65a81aa2;
    logic [31:0] mregs [`EXU_NREG];   // model register file
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    logic        timed_out = 1'b0;    // set once a wait gave up

    exu_top exu_top_inst (.*);

    always #10 clk = ~clk;   // 20 ns period

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw(input int n, output logic [31:0] v);
        v = '0;
        repeat (n) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};   // one step per bit
        end
    endtask

    // {carry, masked result} per the width rules
    function automatic logic [32:0] alu_model(input logic [3:0] op, input logic [1:0] w,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [31:0] m;
        logic [63:0] s;
        logic [31:0] r;
        logic        c;
        logic        found;
        if (w == `W_BYTE) m = 32'h0000_00ff;
        else if (w == `W_WORD) m = 32'h0000_ffff;
        else m = 32'hffff_ffff;
        c = 1'b0;
        r = '0;
        found = 1'b0;
        case (op)
            `ALU_ADD: begin
                s = {32'd0, a & m} + {32'd0, b & m};
                c = (s > {32'd0, m});         // ran past the width
                r = s[31:0];
            end
            `ALU_SUB: begin
                c = ((a & m) < (b & m));      // borrow
                r = (a & m) - (b & m);
            end
            `ALU_AND: r = a & b;
            `ALU_OR:  r = a | b;
            `ALU_XOR: r = a ^ b;
            `ALU_CPL: r = ~a;
            `ALU_BS1F: begin
                for (int i = 0; i < 16; i++) begin
                    if (!found && a[i]) begin
                        r = 32'(i);
                        found = 1'b1;
                    end
                end
            end
            default: r = b;                   // move
        endcase
        return {c, r & m};
    endfunction

    function automatic instr_u reg_instr(input logic [3:0] op, input logic [1:0] w,
            input logic [REG_AW-1:0] dst, input logic [REG_AW-1:0] src, input logic [3:0] rpt);
        instr_u i;
        i.rf = '{op: op, form: 1'b0, w: w, dst: dst, src: src, rpt: rpt, rsvd: '0};
        return i;
    endfunction

    function automatic instr_u imm_instr(input logic [3:0] op, input logic [1:0] w,
            input logic [REG_AW-1:0] dst, input logic [15:0] imm);
        instr_u i;
        i.imf = '{op: op, form: `EXU_FORM_IMM, w: w, dst: dst, imm: imm, rsvd: '0};
        return i;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // later waits and instructions are skipped once this is set
    task automatic report_timeout(input string what);
        $display("timeout at %0t: %s", $time, what);
        timed_out = 1'b1;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        if (timed_out) return;
        while (busy && n < 40) begin
            @(negedge clk);
            n++;
        end
        if (busy) report_timeout("busy never dropped");
    endtask

    // n counts the negedges without done
    task automatic wait_done(output int n);
        n = 0;
        if (timed_out) return;
        @(negedge clk);
        while (!done && n < 40) begin
            n++;
            @(negedge clk);
        end
        if (!done) report_timeout("no done after start");
    endtask

    task automatic load_reg(input logic [REG_AW-1:0] a, input logic [31:0] d);
        wait_idle();
        if (timed_out) return;
        @(posedge clk);
        ld <= '{en: 1'b1, addr: a, data: d};
        @(posedge clk);
        ld <= '0;
    endtask

    task automatic fill_regs();
        logic [31:0] v;
        for (int r = 0; r < `EXU_NREG; r++) begin
            draw(32, v);
            load_reg(REG_AW'(r), v);
            mregs[r] = v;
        end
    endtask

    // one instruction, optionally a second start pushed in while busy
    task automatic run_instr(input instr_u i, input logic inject, input instr_u second);
        logic [32:0]       r;
        logic [31:0]       a;
        logic [31:0]       b;
        logic [REG_AW-1:0] d;
        int                runs;
        int                lat;
        int                n;
        d = i.rf.dst;                         // same spot in both views
        a = mregs[d];
        if (i.rf.form == `EXU_FORM_IMM) begin
            b = {16'd0, i.imf.imm};
            runs = 1;
        end else begin
            b = mregs[i.rf.src];
            runs = int'(i.rf.rpt) + 1;
        end
        r = '0;
        for (int k = 0; k < runs; k++) begin
            r = alu_model(i.rf.op, i.rf.w, a, b);
            a = r[31:0];                      // feeds the next run
        end
        wait_idle();
        if (timed_out) return;
        @(posedge clk);
        start <= 1'b1;
        instr <= i;
        @(posedge clk);
        start <= 1'b0;
        lat = 1;                              // start cycle already behind
        if (inject) begin
            @(posedge clk);
            start <= 1'b1;
            instr <= second;
            @(posedge clk);
            start <= 1'b0;
            lat = 3;
        end
        wait_done(n);
        if (timed_out) return;
        lat = lat + n;
        mregs[d] = a;
        check_value("result", result, a);
        check_value("flags.carry", 32'(flags.carry), 32'(r[32]));
        check_value("flags.zero", 32'(flags.zero), 32'(a == '0));
        check_value("done latency", 32'(lat), 32'(runs + 2));
    endtask

    task automatic end_test(input string name, input int base);
        tests++;
        $display("test %s: %0d errors", name, errors - base);
    endtask

    initial begin
        logic [31:0]       v;
        logic [1:0]        w;
        logic [REG_AW-1:0] dst;
        logic [REG_AW-1:0] src;
        logic [3:0]        op;
        int                base;
        int                chk_fails;
        rst_n = 1'b0;
        start = 1'b0;
        instr = '0;
        ld = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        base = errors;
        check_value("busy", 32'(busy), 32'd0);
        check_value("done", 32'(done), 32'd0);
        check_value("result", result, 32'd0);
        end_test("reset", base);

        // all eight ops, each followed by a MOVE readback of dst
        base = errors;
        for (int k = 0; k < 32; k++) begin
            if (k % 8 == 0) fill_regs();
            draw(2, v);
            w = (v[1:0] == 2'd3) ? `W_LONG : v[1:0];   // code 3 unused
            draw(REG_AW, v);
            dst = v[REG_AW-1:0];
            draw(REG_AW, v);
            src = v[REG_AW-1:0];
            run_instr(reg_instr(4'(k % 8), w, dst, src, 4'd0), 1'b0, '0);
            run_instr(reg_instr(`ALU_MOVE, `W_LONG, dst, dst, 4'd0), 1'b0, '0);
        end
        end_test("register form", base);

        base = errors;
        for (int k = 0; k < 12; k++) begin
            if (k % 3 == 0) op = `ALU_MOVE;
            else if (k % 3 == 1) op = `ALU_ADD;
            else op = `ALU_SUB;
            draw(2, v);
            w = (v[1:0] == 2'd3) ? `W_LONG : v[1:0];
            draw(REG_AW, v);
            dst = v[REG_AW-1:0];
            draw(16, v);
            run_instr(imm_instr(op, w, dst, v[15:0]), 1'b0, '0);
        end
        end_test("immediate form", base);

        // multiply-accumulate chain, latency grows with rpt
        base = errors;
        fill_regs();
        for (int r = 0; r < 16; r++) begin
            draw(2, v);
            w = (v[1:0] == 2'd3) ? `W_LONG : v[1:0];
            draw(REG_AW, v);
            dst = v[REG_AW-1:0];
            draw(REG_AW, v);
            src = v[REG_AW-1:0];
            run_instr(reg_instr(`ALU_ADD, w, dst, src, 4'(r)), 1'b0, '0);
        end
        end_test("repeat", base);

        // second start lands in EXEC and must leave r3 alone
        base = errors;
        run_instr(reg_instr(`ALU_ADD, `W_LONG, 3'd1, 3'd2, 4'd5), 1'b1,
                  imm_instr(`ALU_MOVE, `W_LONG, 3'd3, ~mregs[3][15:0]));
        for (int k = 0; k < 12; k++) begin
            @(negedge clk);
            checks++;
            assert (!done) else begin
                $display("extra done at %0t after a start during busy", $time);
                errors++;
            end
        end
        run_instr(reg_instr(`ALU_MOVE, `W_LONG, 3'd3, 3'd3, 4'd0), 1'b0, '0);
        end_test("start while busy", base);

        chk_fails = int'(exu_top_inst.exu_checker_inst.fails);
        $display("%0d tests, %0d checks, %0d errors, %0d checker failures",
                 tests, checks, errors, chk_fails);
        if (errors == 0 && chk_fails == 0 && !timed_out) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
